// File: hw/lm_ctl.sv
// Local memory controller top with request pipeline, store buffer and RAM port
`timescale 1ns/10ps
`default_nettype none

module lm_ctl #(
    parameter int sb_depth = 4
) (
    input  logic                     lm_clk,
    input  logic                     lm_reset_n,
    input  logic                     a_valid,
    input  logic                     a_write,
    input  logic [lm_pkg::lm_aw-1:0] a_addr,
    input  logic [lm_pkg::lm_uw-1:0] a_user,
    output logic                     a_ready,
    input  logic                     w_valid,
    input  logic [lm_pkg::lm_dw-1:0] w_data,
    input  logic [lm_pkg::lm_bw-1:0] w_mask,
    output logic                     w_ready,
    output logic                     d_valid,
    output logic [lm_pkg::lm_dw-1:0] d_data,
    output logic [lm_pkg::lm_uw-1:0] d_user,
    output logic                     ram_cs,
    output logic                     ram_we,
    output logic [lm_pkg::lm_aw-1:0] ram_addr,
    output logic [lm_pkg::lm_bw-1:0] ram_byte_we,
    output logic [lm_pkg::lm_dw-1:0] ram_wdata,
    input  logic [lm_pkg::lm_dw-1:0] ram_rdata,
    output logic                     lm_standby_ready
);
    import lm_pkg::*;

    logic             rd_req;
    logic [lm_aw-1:0] rd_addr;

    lm_sb_if  sb_if ();
    lm_drn_if drn_if ();

    lm_req_pipe u_req_pipe (
        .lm_clk           (lm_clk),
        .lm_reset_n       (lm_reset_n),
        .a_valid          (a_valid),
        .a_write          (a_write),
        .a_addr           (a_addr),
        .a_user           (a_user),
        .a_ready          (a_ready),
        .w_valid          (w_valid),
        .w_data           (w_data),
        .w_mask           (w_mask),
        .w_ready          (w_ready),
        .d_valid          (d_valid),
        .d_data           (d_data),
        .d_user           (d_user),
        .rd_req           (rd_req),
        .rd_addr          (rd_addr),
        .ram_rdata        (ram_rdata),
        .lm_standby_ready (lm_standby_ready),
        .sb               (sb_if.pipe)
    );

    lm_store_buffer #(
        .sb_depth (sb_depth)
    ) u_store_buffer (
        .lm_clk     (lm_clk),
        .lm_reset_n (lm_reset_n),
        .sb         (sb_if.sb),
        .drn        (drn_if.sb)
    );

    lm_ram_port u_ram_port (
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .drn         (drn_if.port),
        .ram_cs      (ram_cs),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_byte_we (ram_byte_we),
        .ram_wdata   (ram_wdata)
    );

endmodule

`default_nettype wire

// File: hw/lm_drn_if.sv
// Drain channel from the store buffer to the RAM port arbiter
`timescale 1ns/10ps
`default_nettype none

interface lm_drn_if;
    import lm_pkg::*;

    // Oldest entry offered for write-back
    logic             drn_valid;
    logic [lm_aw-1:0] drn_addr;
    logic [lm_dw-1:0] drn_data;
    logic [lm_bw-1:0] drn_mask;
    logic             drn_ready;

    modport sb (
        output drn_valid,
        output drn_addr,
        output drn_data,
        output drn_mask,
        input  drn_ready
    );

    modport port (
        input  drn_valid,
        input  drn_addr,
        input  drn_data,
        input  drn_mask,
        output drn_ready
    );

endinterface

`default_nettype wire

// File: hw/lm_pkg.sv
// Local memory controller shared widths and byte merge helper
`default_nettype none

package lm_pkg;

    // Data word and its byte lanes
    localparam int lm_dw = 64;
    localparam int lm_bw = lm_dw / 8;

    // Word address and request tag
    localparam int lm_aw = 8;
    localparam int lm_uw = 4;

    // Overlay the masked bytes of upd onto base
    function automatic logic [lm_dw-1:0] lm_merge(
        input logic [lm_dw-1:0] base,
        input logic [lm_dw-1:0] upd,
        input logic [lm_bw-1:0] mask
    );
        logic [lm_dw-1:0] res;
        res = base;
        for (int b = 0; b < lm_bw; b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = upd[b*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// File: hw/lm_ram_port.sv
// Fixed-priority arbiter between reads and store-buffer drains on the RAM port
`timescale 1ns/10ps
`default_nettype none

module lm_ram_port (
    input  logic                     rd_req,
    input  logic [lm_pkg::lm_aw-1:0] rd_addr,
    lm_drn_if.port                   drn,
    output logic                     ram_cs,
    output logic                     ram_we,
    output logic [lm_pkg::lm_aw-1:0] ram_addr,
    output logic [lm_pkg::lm_bw-1:0] ram_byte_we,
    output logic [lm_pkg::lm_dw-1:0] ram_wdata
);

    logic grant_rd;
    logic grant_drn;

    // Reads always win and drains take the idle cycles
    assign grant_rd  = rd_req;
    assign grant_drn = drn.drn_valid & ~rd_req;

    assign drn.drn_ready = ~grant_rd;

    assign ram_cs      = grant_rd | grant_drn;
    assign ram_we      = grant_drn;
    assign ram_addr    = grant_rd ? rd_addr : drn.drn_addr;
    assign ram_byte_we = grant_drn ? drn.drn_mask : '0;
    assign ram_wdata   = drn.drn_data;

endmodule

`default_nettype wire

// File: hw/lm_req_pipe.sv
// Two-stage load/store request pipeline with write-data capture and read merge
`timescale 1ns/10ps
`default_nettype none

module lm_req_pipe (
    input  logic                     lm_clk,
    input  logic                     lm_reset_n,
    input  logic                     a_valid,
    input  logic                     a_write,
    input  logic [lm_pkg::lm_aw-1:0] a_addr,
    input  logic [lm_pkg::lm_uw-1:0] a_user,
    output logic                     a_ready,
    input  logic                     w_valid,
    input  logic [lm_pkg::lm_dw-1:0] w_data,
    input  logic [lm_pkg::lm_bw-1:0] w_mask,
    output logic                     w_ready,
    output logic                     d_valid,
    output logic [lm_pkg::lm_dw-1:0] d_data,
    output logic [lm_pkg::lm_uw-1:0] d_user,
    output logic                     rd_req,
    output logic [lm_pkg::lm_aw-1:0] rd_addr,
    input  logic [lm_pkg::lm_dw-1:0] ram_rdata,
    output logic                     lm_standby_ready,
    lm_sb_if.pipe                    sb
);
    import lm_pkg::*;

    logic             stall;
    logic             accept;
    logic             s1_adv;

    // Stage 1
    logic             s1_valid;
    logic             s1_first;
    logic             s1_write;
    logic [lm_aw-1:0] s1_addr;
    logic [lm_uw-1:0] s1_user;
    logic [lm_dw-1:0] s1_data;
    logic [lm_dw-1:0] s1_base;
    logic [lm_bw-1:0] s1_hit_mask;

    // Stage 2
    logic             s2_valid;
    logic             s2_write;
    logic [lm_aw-1:0] s2_addr;
    logic [lm_uw-1:0] s2_user;
    logic [lm_dw-1:0] s2_rdata;
    logic [lm_dw-1:0] s2_hit_data;
    logic [lm_bw-1:0] s2_hit_mask;

    // Only a write waiting for its data holds the pipe
    assign stall   = s2_valid & s2_write & ~w_valid;
    assign a_ready = ~stall & ~sb.full;
    assign accept  = a_valid & a_ready;
    assign s1_adv  = s1_valid & ~stall;

    assign rd_req  = accept & ~a_write;
    assign rd_addr = a_addr;

    // RAM word is live only in the first stage-1 cycle
    assign s1_base     = s1_first ? ram_rdata : s1_data;
    assign s1_hit_mask = sb.hit ? sb.hit_mask : '0;
    assign sb.cmp_addr = s1_addr;

    always_ff @(posedge lm_clk or negedge lm_reset_n) begin
        if (!lm_reset_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s1_first <= 1'b0;
        end else if (!stall) begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
            s1_first <= accept;
        end else begin
            s1_first <= 1'b0;
        end
    end

    always_ff @(posedge lm_clk) begin
        if (accept) begin
            s1_write <= a_write;
            s1_addr  <= a_addr;
            s1_user  <= a_user;
        end
        // Fold in buffer bytes that may drain while stalled
        if (stall && s1_valid) begin
            s1_data <= lm_merge(s1_base, sb.hit_data, s1_hit_mask);
        end
        if (s1_adv) begin
            s2_write    <= s1_write;
            s2_addr     <= s1_addr;
            s2_user     <= s1_user;
            s2_rdata    <= s1_base;
            s2_hit_data <= sb.hit_data;
            s2_hit_mask <= s1_hit_mask;
        end
    end

    // Write data is taken straight into the store buffer
    assign w_ready      = s2_valid & s2_write;
    assign sb.enq_valid = w_ready & w_valid;
    assign sb.enq_addr  = s2_addr;
    assign sb.enq_data  = w_data;
    assign sb.enq_mask  = w_mask;

    assign d_valid = s2_valid & ~stall;
    assign d_user  = s2_user;
    assign d_data  = lm_merge(s2_rdata, s2_hit_data, s2_hit_mask);

    assign lm_standby_ready = ~s1_valid & ~s2_valid & sb.empty;

endmodule

`default_nettype wire

// File: hw/lm_sb_if.sv
// Lookup and enqueue channel between the request pipeline and the store buffer
`timescale 1ns/10ps
`default_nettype none

interface lm_sb_if;
    import lm_pkg::*;

    // Address compare answered combinationally
    logic [lm_aw-1:0] cmp_addr;
    logic             hit;
    logic [lm_dw-1:0] hit_data;
    logic [lm_bw-1:0] hit_mask;

    // Single-cycle enqueue strobe
    logic             enq_valid;
    logic [lm_aw-1:0] enq_addr;
    logic [lm_dw-1:0] enq_data;
    logic [lm_bw-1:0] enq_mask;

    // Occupancy levels
    logic             full;
    logic             empty;

    modport pipe (
        output cmp_addr,
        output enq_valid,
        output enq_addr,
        output enq_data,
        output enq_mask,
        input  hit,
        input  hit_data,
        input  hit_mask,
        input  full,
        input  empty
    );

    modport sb (
        input  cmp_addr,
        input  enq_valid,
        input  enq_addr,
        input  enq_data,
        input  enq_mask,
        output hit,
        output hit_data,
        output hit_mask,
        output full,
        output empty
    );

endinterface

`default_nettype wire

// File: hw/lm_store_buffer.sv
// Write-combining store buffer with address lookup, enqueue and in-order drain
`timescale 1ns/10ps
`default_nettype none

module lm_store_buffer #(
    parameter int sb_depth = 4
) (
    input  logic lm_clk,
    input  logic lm_reset_n,
    lm_sb_if.sb  sb,
    lm_drn_if.sb drn
);
    import lm_pkg::*;

    // Room kept for the two requests in flight plus the one being accepted
    localparam int sb_reserve = 3;

    // Entry 0 is the oldest
    logic [sb_depth-1:0] e_valid;
    logic [lm_aw-1:0]    e_addr [sb_depth];
    logic [lm_dw-1:0]    e_data [sb_depth];
    logic [lm_bw-1:0]    e_mask [sb_depth];

    logic [sb_depth-1:0] n_valid;
    logic [lm_aw-1:0]    n_addr [sb_depth];
    logic [lm_dw-1:0]    n_data [sb_depth];
    logic [lm_bw-1:0]    n_mask [sb_depth];

    logic                drain;
    logic                merge_hit;
    int                  merge_idx;
    int                  tail;
    int                  free_cnt;

    logic                lk_hit;
    logic [lm_dw-1:0]    lk_data;
    logic [lm_bw-1:0]    lk_mask;

    assign drain = e_valid[0] & drn.drn_ready;

    // Newer bytes override older ones in the lookup
    always_comb begin
        lk_hit  = 1'b0;
        lk_data = '0;
        lk_mask = '0;
        for (int i = 0; i < sb_depth; i++) begin
            if (e_valid[i] && e_addr[i] == sb.cmp_addr) begin
                lk_hit  = 1'b1;
                lk_data = lm_merge(lk_data, e_data[i], e_mask[i]);
                lk_mask = lk_mask | e_mask[i];
            end
        end
        // Same-cycle enqueue is the newest of all
        if (sb.enq_valid && sb.enq_addr == sb.cmp_addr) begin
            lk_hit  = 1'b1;
            lk_data = lm_merge(lk_data, sb.enq_data, sb.enq_mask);
            lk_mask = lk_mask | sb.enq_mask;
        end
    end

    assign sb.hit      = lk_hit;
    assign sb.hit_data = lk_data;
    assign sb.hit_mask = lk_mask;

    // Lowest free slot
    always_comb begin
        tail     = 0;
        free_cnt = 0;
        for (int i = sb_depth - 1; i >= 0; i--) begin
            if (!e_valid[i]) begin
                tail     = i;
                free_cnt = free_cnt + 1;
            end
        end
    end

    always_comb begin
        n_valid   = e_valid;
        n_addr    = e_addr;
        n_data    = e_data;
        n_mask    = e_mask;
        merge_hit = 1'b0;
        merge_idx = 0;

        // An entry leaving this cycle cannot take more bytes
        for (int i = 0; i < sb_depth; i++) begin
            if (e_valid[i] && e_addr[i] == sb.enq_addr && !(i == 0 && drain)) begin
                merge_hit = 1'b1;
                merge_idx = i;
            end
        end

        if (sb.enq_valid) begin
            if (merge_hit) begin
                n_data[merge_idx] = lm_merge(e_data[merge_idx], sb.enq_data, sb.enq_mask);
                n_mask[merge_idx] = e_mask[merge_idx] | sb.enq_mask;
            end else begin
                n_valid[tail] = 1'b1;
                n_addr[tail]  = sb.enq_addr;
                n_data[tail]  = sb.enq_data;
                n_mask[tail]  = sb.enq_mask;
            end
        end

        // Shift toward the head after a drain
        if (drain) begin
            for (int i = 0; i < sb_depth - 1; i++) begin
                n_valid[i] = n_valid[i+1];
                n_addr[i]  = n_addr[i+1];
                n_data[i]  = n_data[i+1];
                n_mask[i]  = n_mask[i+1];
            end
            n_valid[sb_depth-1] = 1'b0;
        end
    end

    always_ff @(posedge lm_clk or negedge lm_reset_n) begin
        if (!lm_reset_n) begin
            e_valid <= '0;
        end else begin
            e_valid <= n_valid;
        end
    end

    always_ff @(posedge lm_clk) begin
        e_addr <= n_addr;
        e_data <= n_data;
        e_mask <= n_mask;
    end

    assign sb.full  = free_cnt < sb_reserve;
    assign sb.empty = ~|e_valid;

    assign drn.drn_valid = e_valid[0];
    assign drn.drn_addr  = e_addr[0];
    assign drn.drn_data  = e_data[0];
    assign drn.drn_mask  = e_mask[0];

endmodule

`default_nettype wire

// File: list.f
hw/lm_pkg.sv
hw/lm_sb_if.sv
hw/lm_drn_if.sv
hw/lm_req_pipe.sv
hw/lm_store_buffer.sv
hw/lm_ram_port.sv
hw/lm_ctl.sv
tb/lm_checker.sv
tb/tb_lm_ctl.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for the result
verilator --binary --timing --top-module tb_lm_ctl -f list.f -o tb_lm_ctl \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_lm_ctl > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"

// File: tb/lm_checker.sv
// Response checker for the local memory controller with reference model and error counts
`timescale 1ns/10ps
`default_nettype none

module lm_checker #(
    parameter logic [lm_pkg::lm_dw-1:0] fill_key = '0
) (
    input  logic                     lm_clk,
    input  logic                     lm_reset_n,
    input  logic                     quiet,
    input  logic                     a_valid,
    input  logic                     a_write,
    input  logic [lm_pkg::lm_aw-1:0] a_addr,
    input  logic [lm_pkg::lm_uw-1:0] a_user,
    input  logic                     a_ready,
    input  logic                     w_valid,
    input  logic [lm_pkg::lm_dw-1:0] w_data,
    input  logic [lm_pkg::lm_bw-1:0] w_mask,
    input  logic                     w_ready,
    input  logic                     d_valid,
    input  logic [lm_pkg::lm_dw-1:0] d_data,
    input  logic [lm_pkg::lm_uw-1:0] d_user,
    input  logic                     ram_cs,
    input  logic                     ram_we,
    input  logic [lm_pkg::lm_aw-1:0] ram_addr,
    input  logic [lm_pkg::lm_bw-1:0] ram_byte_we,
    input  logic [lm_pkg::lm_dw-1:0] ram_wdata,
    input  logic                     lm_standby_ready,
    output int                       err_cnt,
    output int                       rsp_cnt
);
    import lm_pkg::*;

    typedef struct packed {
        logic             wr;
        logic [lm_aw-1:0] addr;
        logic [lm_uw-1:0] user;
        logic [31:0]      n_wr;
    } req_t;

    // Outstanding requests with the oldest first
    req_t             pend [$];

    // Write data in handshake order
    logic [lm_aw-1:0] log_addr [$];
    logic [lm_dw-1:0] log_data [$];
    logic [lm_bw-1:0] log_mask [$];

    // Latest enqueued bytes per word
    logic [lm_dw-1:0] shadow [1 << lm_aw];
    logic [lm_bw-1:0] seen [1 << lm_aw];

    int               errs = 0;
    int               rsps = 0;
    int               n_wr_acc = 0;

    assign err_cnt = errs;
    assign rsp_cnt = rsps;

    function automatic logic [lm_dw-1:0] initial_word(input logic [lm_aw-1:0] a);
        return {lm_bw{a}} ^ fill_key;
    endfunction

    // Fill pattern overlaid with the first n accepted writes to word a
    function automatic logic [lm_dw-1:0] expected_word(input logic [lm_aw-1:0] a,
                                                       input logic [31:0] n);
        logic [lm_dw-1:0] w;
        w = initial_word(a);
        for (int k = 0; k < int'(n); k++) begin
            if (log_addr[k] == a) begin
                for (int b = 0; b < lm_bw; b++) begin
                    if (log_mask[k][b]) begin
                        w[b*8 +: 8] = log_data[k][b*8 +: 8];
                    end
                end
            end
        end
        return w;
    endfunction

    task automatic check_word(input string name, input logic [lm_dw-1:0] got,
                              input logic [lm_dw-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            errs++;
        end
    endtask

    task automatic protocol_fault(input string what);
        $display("Fault at %0t: %s", $time, what);
        errs++;
    endtask

    always @(negedge lm_clk) begin
        req_t             head;
        req_t             nreq;
        logic             have_head;
        logic [lm_dw-1:0] m;
        have_head = 1'b0;
        if (!lm_reset_n) begin
            foreach (seen[i]) begin
                seen[i] = '0;
            end
            check_bit("d_valid", d_valid, 1'b0);
            check_bit("w_ready", w_ready, 1'b0);
            check_bit("ram_cs", ram_cs, 1'b0);
            check_bit("ram_we", ram_we, 1'b0);
            check_bit("a_ready", a_ready, 1'b1);
            check_bit("lm_standby_ready", lm_standby_ready, 1'b1);
        end else begin
            // Write in stage 2 waiting for its data
            if (w_ready && !w_valid) begin
                check_bit("a_ready", a_ready, 1'b0);
                check_bit("d_valid", d_valid, 1'b0);
            end

            // Accepted requests still in the pipeline
            if (pend.size() != 0) begin
                check_bit("lm_standby_ready", lm_standby_ready, 1'b0);
            end

            // Drained bytes compared before this cycle's write data lands
            if (ram_cs && ram_we) begin
                for (int b = 0; b < lm_bw; b++) begin
                    m[b*8 +: 8] = {8{ram_byte_we[b]}};
                end
                if ((ram_byte_we & ~seen[ram_addr]) != '0) begin
                    protocol_fault("RAM write covers bytes that were never enqueued");
                end
                check_word("ram_wdata", ram_wdata & m, shadow[ram_addr] & m);
            end

            if (d_valid) begin
                if (pend.size() == 0) begin
                    protocol_fault("d_valid without an outstanding request");
                end else begin
                    head = pend.pop_front();
                    have_head = 1'b1;
                    rsps++;
                    check_word("d_user", lm_dw'(d_user), lm_dw'(head.user));
                    if (head.wr) begin
                        if (!(w_valid && w_ready)) begin
                            protocol_fault("write response without its data handshake");
                        end
                    end else begin
                        check_word("d_data", d_data, expected_word(head.addr, head.n_wr));
                    end
                end
            end

            if (w_valid && w_ready) begin
                if (!have_head || !head.wr) begin
                    protocol_fault("write data taken outside a write response");
                end else begin
                    log_addr.push_back(head.addr);
                    log_data.push_back(w_data);
                    log_mask.push_back(w_mask);
                    for (int b = 0; b < lm_bw; b++) begin
                        if (w_mask[b]) begin
                            shadow[head.addr][b*8 +: 8] = w_data[b*8 +: 8];
                        end
                    end
                    seen[head.addr] = seen[head.addr] | w_mask;
                end
            end

            if (a_valid && a_ready) begin
                nreq.wr   = a_write;
                nreq.addr = a_addr;
                nreq.user = a_user;
                nreq.n_wr = n_wr_acc;
                pend.push_back(nreq);
                if (a_write) begin
                    n_wr_acc++;
                end
            end

            // Nothing may be left in flight in the idle tail
            if (quiet) begin
                check_bit("lm_standby_ready", lm_standby_ready, 1'b1);
                check_bit("ram_cs", ram_cs, 1'b0);
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_lm_ctl.sv
// Testbench for the local memory controller with RAM model, random traffic and run limit
`timescale 1ns/10ps
`default_nettype none

module tb_lm_ctl;
    import lm_pkg::*;

    localparam int               n_ops       = 2000;
    localparam int               cycle_limit = 20 * n_ops + 1000;
    localparam logic [31:0]      seed        = 32'h1017_c32f;
    localparam logic [lm_dw-1:0] fill_key    = 64'h3c5a_9617_e2d4_0b81;
    localparam logic [lm_aw-1:0] win_base    = 8'h20;

    logic             lm_clk = 1'b0;
    logic             lm_reset_n;
    logic             a_valid;
    logic             a_write;
    logic [lm_aw-1:0] a_addr;
    logic [lm_uw-1:0] a_user;
    logic             a_ready;
    logic             w_valid;
    logic [lm_dw-1:0] w_data;
    logic [lm_bw-1:0] w_mask;
    logic             w_ready;
    logic             d_valid;
    logic [lm_dw-1:0] d_data;
    logic [lm_uw-1:0] d_user;
    logic             ram_cs;
    logic             ram_we;
    logic [lm_aw-1:0] ram_addr;
    logic [lm_bw-1:0] ram_byte_we;
    logic [lm_dw-1:0] ram_wdata;
    logic [lm_dw-1:0] ram_rdata = '0;
    logic             lm_standby_ready;

    logic             quiet;
    logic             a_taken = 1'b0;
    int               err_cnt;
    int               rsp_cnt;
    int               cycles = 0;
    int               n_sent;
    int               gap;
    int               wr_pct;
    int               w_pct;
    logic [lm_dw-1:0] ram [1 << lm_aw];

    always #4 lm_clk = ~lm_clk;

    function automatic logic [lm_dw-1:0] fill_word(input logic [lm_aw-1:0] a);
        return {lm_bw{a}} ^ fill_key;
    endfunction

    // RAM answers reads one cycle late and is refilled while reset is held
    always @(posedge lm_clk) begin
        if (!lm_reset_n) begin
            for (int i = 0; i < (1 << lm_aw); i++) begin
                ram[i] <= fill_word(i[lm_aw-1:0]);
            end
        end else if (ram_cs && !ram_we) begin
            ram_rdata <= ram[ram_addr];
        end else if (ram_cs && ram_we) begin
            for (int b = 0; b < lm_bw; b++) begin
                if (ram_byte_we[b]) begin
                    ram[ram_addr][b*8 +: 8] <= ram_wdata[b*8 +: 8];
                end
            end
        end
    end

    always @(negedge lm_clk) begin
        a_taken = a_valid & a_ready;
    end

    always @(posedge lm_clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d responses, %0d errors",
                     cycles, rsp_cnt, n_ops, err_cnt);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic drive_w(input int pct);
        w_valid = ($urandom % 100) < pct;
        w_data  = {$urandom, $urandom};
        w_mask  = lm_bw'($urandom);
    endtask

    // Reads mostly hit a narrow window and some go anywhere
    task automatic issue_request(input int pct);
        logic wr;
        wr      = ($urandom % 100) < pct;
        a_valid = 1'b1;
        a_write = wr;
        if (wr || ($urandom % 8) != 0) begin
            a_addr = win_base + lm_aw'($urandom % 8);
        end else begin
            a_addr = lm_aw'($urandom);
        end
        a_user = lm_uw'($urandom);
        gap    = (($urandom % 16) == 0) ? int'($urandom % 24) : 0;
    endtask

    lm_ctl dut (.*);

    lm_checker #(
        .fill_key (fill_key)
    ) u_checker (.*);

    initial begin
        void'($urandom(seed));
        lm_reset_n = 1'b0;
        a_valid    = 1'b0;
        a_write    = 1'b0;
        a_addr     = '0;
        a_user     = '0;
        w_valid    = 1'b0;
        w_data     = '0;
        w_mask     = '0;
        quiet      = 1'b0;
        n_sent     = 0;
        gap        = 0;
        repeat (2) @(posedge lm_clk);
        #1;
        lm_reset_n = 1'b1;

        while (n_sent < n_ops) begin
            @(posedge lm_clk);
            #1;
            // Phases of mixed traffic, write bursts and read streams
            case ((n_sent / 250) % 4)
                1: begin
                    wr_pct = 90;
                    w_pct  = 35;
                end
                2: begin
                    wr_pct = 10;
                    w_pct  = 90;
                end
                default: begin
                    wr_pct = 50;
                    w_pct  = 75;
                end
            endcase
            drive_w(w_pct);
            if (a_valid && a_taken) begin
                a_valid = 1'b0;
                n_sent++;
            end
            if (!a_valid && n_sent < n_ops) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    issue_request(wr_pct);
                end
            end
        end

        while (rsp_cnt < n_ops) begin
            @(posedge lm_clk);
            #1;
            drive_w(100);
        end
        w_valid = 1'b0;

        // Let the store buffer empty, then watch for stray activity
        repeat (16) begin
            @(posedge lm_clk);
            #1;
        end
        quiet = 1'b1;
        repeat (16) begin
            @(posedge lm_clk);
            #1;
        end
        quiet = 1'b0;

        $display("Run complete after %0d cycles, %0d responses, %0d errors",
                 cycles, rsp_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
